//--- hw/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
    import cpu_types_pkg::*;
    import isa_pkg::*;
(
    // forwarded operands for this lane
    rd_port_if.requester fwd,
    input  logic         issue_valid,
    input  alu_op_t      op,
    input  reg_addr_t    dest,
    output uint32_t      result,
    output reg_addr_t    result_waddr,
    output logic         result_we
);

    uint32_t    op_a;
    uint32_t    op_b;
    logic [4:0] shamt;

    assign op_a  = fwd.rdata1;
    assign op_b  = fwd.rdata2;
    // shift amount from the low bits of operand 2
    assign shamt = op_b[4:0];

    always_comb begin
        result = '0;
        case (op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            // signed less-than yields 0 or 1
            ALU_SLT: result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            ALU_SLL: result = op_a << shamt;
            ALU_SRL: result = op_a >> shamt;
            default: result = '0;
        endcase
    end

    // destination travels with the result
    assign result_waddr = dest;
    // register 0 filtering happens in writeback
    assign result_we    = issue_valid;

endmodule

`default_nettype wire

//--- hw/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// sizing of the integer register file and datapath

// architectural registers including the zero register
`define REG_NUM 32

// bits needed to name one register
`define REG_ADDR_W 5

// width of one datapath word
`define DATA_W 32

// register 0 reads as zero and ignores writes
// a write port has one enable bit per byte of DATA_W
// any set enable bit stores the whole word

`endif

//--- hw/cpu_types_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_types_pkg;

    // register number as seen on read and write ports
    // value 0 selects the hard-wired zero register
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // one integer word of the datapath
    // operands, results and load data all use it
    typedef logic [`DATA_W-1:0] uint32_t;

    // write port enable with one bit per byte lane
    // the register file treats any set bit as a full word write
    typedef logic [`DATA_W/8-1:0] byte_en_t;

endpackage

`default_nettype wire

//--- hw/dual_issue_core.sv
`timescale 1ns/10ps
`default_nettype none

module dual_issue_core
    import cpu_types_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // issue lane 1
    input  logic      i1_valid,
    input  alu_op_t   i1_op,
    input  reg_addr_t i1_rs,
    input  reg_addr_t i1_rt,
    input  reg_addr_t i1_rd,
    // issue lane 2
    input  logic      i2_valid,
    input  alu_op_t   i2_op,
    input  reg_addr_t i2_rs,
    input  reg_addr_t i2_rt,
    input  reg_addr_t i2_rd,
    // load return
    input  logic      load_valid,
    input  reg_addr_t load_waddr,
    input  uint32_t   load_data,
    // results one cycle after issue
    output logic      res1_valid,
    output uint32_t   res1_data,
    output logic      res2_valid,
    output uint32_t   res2_data
);

    // raw links between regfile and bypass
    rd_port_if raw1 ();
    rd_port_if raw2 ();
    // forwarded links between bypass and the ALUs
    rd_port_if fwd1 ();
    rd_port_if fwd2 ();

    // ALU outputs into writeback
    uint32_t   lane1_result;
    reg_addr_t lane1_waddr;
    logic      lane1_we;
    uint32_t   lane2_result;
    reg_addr_t lane2_waddr;
    logic      lane2_we;

    // write ports shared by regfile and bypass
    byte_en_t  we1;
    reg_addr_t waddr1;
    uint32_t   wdata1;
    byte_en_t  we2;
    reg_addr_t waddr2;
    uint32_t   wdata2;
    byte_en_t  we3;
    reg_addr_t waddr3;
    uint32_t   wdata3;

    // source registers from the issue ports onto both links of each lane
    assign raw1.raddr1 = i1_rs;
    assign raw1.raddr2 = i1_rt;
    assign fwd1.raddr1 = i1_rs;
    assign fwd1.raddr2 = i1_rt;
    assign raw2.raddr1 = i2_rs;
    assign raw2.raddr2 = i2_rt;
    assign fwd2.raddr1 = i2_rs;
    assign fwd2.raddr2 = i2_rt;

    regfile i_regfile (
        .clk    (clk),
        .rd1    (raw1.file),
        .rd2    (raw2.file),
        .we1    (we1),
        .waddr1 (waddr1),
        .wdata1 (wdata1),
        .we2    (we2),
        .waddr2 (waddr2),
        .wdata2 (wdata2),
        .we3    (we3),
        .waddr3 (waddr3),
        .wdata3 (wdata3)
    );

    operand_bypass i_operand_bypass (
        .raw1   (raw1.bypass),
        .raw2   (raw2.bypass),
        .fwd1   (fwd1.file),
        .fwd2   (fwd2.file),
        .we1    (we1),
        .waddr1 (waddr1),
        .wdata1 (wdata1),
        .we2    (we2),
        .waddr2 (waddr2),
        .wdata2 (wdata2),
        .we3    (we3),
        .waddr3 (waddr3),
        .wdata3 (wdata3)
    );

    alu i_alu1 (
        .fwd          (fwd1.requester),
        .issue_valid  (i1_valid),
        .op           (i1_op),
        .dest         (i1_rd),
        .result       (lane1_result),
        .result_waddr (lane1_waddr),
        .result_we    (lane1_we)
    );

    alu i_alu2 (
        .fwd          (fwd2.requester),
        .issue_valid  (i2_valid),
        .op           (i2_op),
        .dest         (i2_rd),
        .result       (lane2_result),
        .result_waddr (lane2_waddr),
        .result_we    (lane2_we)
    );

    writeback_stage i_writeback_stage (
        .clk          (clk),
        .rst          (rst),
        .lane1_result (lane1_result),
        .lane1_waddr  (lane1_waddr),
        .lane1_we     (lane1_we),
        .lane2_result (lane2_result),
        .lane2_waddr  (lane2_waddr),
        .lane2_we     (lane2_we),
        .load_valid   (load_valid),
        .load_waddr   (load_waddr),
        .load_data    (load_data),
        .we1          (we1),
        .waddr1       (waddr1),
        .wdata1       (wdata1),
        .we2          (we2),
        .waddr2       (waddr2),
        .wdata2       (wdata2),
        .we3          (we3),
        .waddr3       (waddr3),
        .wdata3       (wdata3),
        .res1_valid   (res1_valid),
        .res1_data    (res1_data),
        .res2_valid   (res2_valid),
        .res2_data    (res2_data)
    );

endmodule

`default_nettype wire

//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // ALU operation selector carried with each issued instruction
    typedef logic [2:0] alu_op_t;

    // arithmetic
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;

    // bitwise logic
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;

    // signed compare, result is 1 or 0
    localparam alu_op_t ALU_SLT = 3'd5;

    // logical shifts by the low 5 bits of operand 2
    localparam alu_op_t ALU_SLL = 3'd6;
    localparam alu_op_t ALU_SRL = 3'd7;

endpackage

`default_nettype wire

//--- hw/operand_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module operand_bypass
    import cpu_types_pkg::*;
(
    // raw register file data per lane
    rd_port_if.bypass raw1,
    rd_port_if.bypass raw2,
    // forwarded operands toward each ALU
    rd_port_if.file   fwd1,
    rd_port_if.file   fwd2,
    // lane 1 result port
    input  byte_en_t  we1,
    input  reg_addr_t waddr1,
    input  uint32_t   wdata1,
    // lane 2 result port
    input  byte_en_t  we2,
    input  reg_addr_t waddr2,
    input  uint32_t   wdata2,
    // load return port
    input  byte_en_t  we3,
    input  reg_addr_t waddr3,
    input  uint32_t   wdata3
);

    // per-port address hits for each of the four reads
    // no register 0 check needed here
    // writeback never enables a write to register 0
    function automatic logic hit(input byte_en_t we, input reg_addr_t waddr,
                                 input reg_addr_t raddr);
        return (|we) && (waddr == raddr);
    endfunction

    // pick the data the register file will hold after this cycle
    // checked in ascending priority so the load port has the last word
    function automatic uint32_t pick(input reg_addr_t raddr, input uint32_t raw);
        uint32_t data;
        data = raw;
        if (hit(we1, waddr1, raddr)) begin
            data = wdata1;
        end
        if (hit(we2, waddr2, raddr)) begin
            data = wdata2;
        end
        if (hit(we3, waddr3, raddr)) begin
            data = wdata3;
        end
        return data;
    endfunction

    // lane 1 operands
    // addresses come from the forwarded link this block sources
    always_comb begin
        fwd1.rdata1 = pick(fwd1.raddr1, raw1.rdata1);
        fwd1.rdata2 = pick(fwd1.raddr2, raw1.rdata2);
    end

    // lane 2 operands
    // lane 1 of the same bundle is not visible here yet
    always_comb begin
        fwd2.rdata1 = pick(fwd2.raddr1, raw2.rdata1);
        fwd2.rdata2 = pick(fwd2.raddr2, raw2.rdata2);
    end

endmodule

`default_nettype wire

//--- hw/rd_port_if.sv
`timescale 1ns/10ps
`default_nettype none

// one lane's pair of register read ports
interface rd_port_if
    import cpu_types_pkg::*;
();

    // source register numbers
    reg_addr_t raddr1;
    reg_addr_t raddr2;

    // operand data for those registers
    uint32_t   rdata1;
    uint32_t   rdata2;

    // issue side asks for operands and consumes them
    modport requester (output raddr1, output raddr2, input rdata1, input rdata2);

    // observer of a raw link
    // sees the addresses and the register file data
    modport bypass (input raddr1, input raddr2, input rdata1, input rdata2);

    // data source of a link
    // register file on the raw link, bypass on the forwarded link
    modport file (input raddr1, input raddr2, output rdata1, output rdata2);

endinterface

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module regfile
    import cpu_types_pkg::*;
(
    input  logic      clk,
    // two read pairs, one per issue lane
    rd_port_if.file   rd1,
    rd_port_if.file   rd2,
    // lane 1 result port
    input  byte_en_t  we1,
    input  reg_addr_t waddr1,
    input  uint32_t   wdata1,
    // lane 2 result port
    input  byte_en_t  we2,
    input  reg_addr_t waddr2,
    input  uint32_t   wdata2,
    // load return port
    input  byte_en_t  we3,
    input  reg_addr_t waddr3,
    input  uint32_t   wdata3
);

    // storage has no reset
    uint32_t regs [0:`REG_NUM-1];

    // register 0 is forced to zero on the read side
    function automatic uint32_t read_reg(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        return regs[addr];
    endfunction

    // any enable bit writes the full word
    // later statements override earlier ones for the same register
    // so port 3 beats port 2 and port 2 beats port 1
    always_ff @(posedge clk) begin
        if (|we1) begin
            regs[waddr1] <= wdata1;
        end
        if (|we2) begin
            regs[waddr2] <= wdata2;
        end
        if (|we3) begin
            regs[waddr3] <= wdata3;
        end
    end

    // four asynchronous reads
    always_comb begin
        rd1.rdata1 = read_reg(rd1.raddr1);
        rd1.rdata2 = read_reg(rd1.raddr2);
    end

    always_comb begin
        rd2.rdata1 = read_reg(rd2.raddr1);
        rd2.rdata2 = read_reg(rd2.raddr2);
    end

endmodule

`default_nettype wire

//--- hw/writeback_stage.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_stage
    import cpu_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // lane 1 result from its ALU
    input  uint32_t   lane1_result,
    input  reg_addr_t lane1_waddr,
    input  logic      lane1_we,
    // lane 2 result from its ALU
    input  uint32_t   lane2_result,
    input  reg_addr_t lane2_waddr,
    input  logic      lane2_we,
    // load return from the memory unit
    input  logic      load_valid,
    input  reg_addr_t load_waddr,
    input  uint32_t   load_data,
    // register file write port 1
    output byte_en_t  we1,
    output reg_addr_t waddr1,
    output uint32_t   wdata1,
    // register file write port 2
    output byte_en_t  we2,
    output reg_addr_t waddr2,
    output uint32_t   wdata2,
    // register file write port 3
    output byte_en_t  we3,
    output reg_addr_t waddr3,
    output uint32_t   wdata3,
    // reported results one cycle after issue
    output logic      res1_valid,
    output uint32_t   res1_data,
    output logic      res2_valid,
    output uint32_t   res2_data
);

    // single enable bit widened to all byte lanes
    // writes aimed at register 0 are dropped here
    function automatic byte_en_t full_we(input logic en, input reg_addr_t waddr);
        return (en && (waddr != '0)) ? '1 : '0;
    endfunction

    // enables and valid flags
    always_ff @(posedge clk) begin
        if (rst) begin
            we1        <= '0;
            we2        <= '0;
            we3        <= '0;
            res1_valid <= 1'b0;
            res2_valid <= 1'b0;
        end else begin
            we1        <= full_we(lane1_we, lane1_waddr);
            we2        <= full_we(lane2_we, lane2_waddr);
            we3        <= full_we(load_valid, load_waddr);
            // reported even when the destination is register 0
            res1_valid <= lane1_we;
            res2_valid <= lane2_we;
        end
    end

    // address and data payload
    always_ff @(posedge clk) begin
        waddr1 <= lane1_waddr;
        wdata1 <= lane1_result;
        waddr2 <= lane2_waddr;
        wdata2 <= lane2_result;
        waddr3 <= load_waddr;
        wdata3 <= load_data;
    end

    // the reported value is the one being written back
    assign res1_data = wdata1;
    assign res2_data = wdata2;

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/cpu_types_pkg.sv
hw/isa_pkg.sv
hw/rd_port_if.sv
hw/regfile.sv
hw/operand_bypass.sv
hw/alu.sv
hw/writeback_stage.sv
hw/dual_issue_core.sv
tb/dual_issue_core_assert.sv
tb/dual_issue_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module dual_issue_core_tb -f project.f > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vdual_issue_core_tb > sim.log 2>&1 \
    || echo "simulator exited with an error status" >> sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation did not complete, see sim.log"; exit 1; }
echo "simulation passed"

//--- tb/dual_issue_core_assert.sv
`timescale 1ns/10ps
`default_nettype none

module dual_issue_core_assert
    import cpu_types_pkg::*;
(
    input logic      clk,
    input logic      rst,
    // issue side of writeback
    input logic      lane1_we,
    input logic      lane2_we,
    // registered write ports
    input byte_en_t  we1,
    input reg_addr_t waddr1,
    input byte_en_t  we2,
    input reg_addr_t waddr2,
    input byte_en_t  we3,
    input reg_addr_t waddr3,
    // reported result flags
    input logic      res1_valid,
    input logic      res2_valid
);

    // nothing is written in the cycle after a reset cycle
    we_clear_after_rst: assert property (@(posedge clk)
        rst |=> (we1 == '0) && (we2 == '0) && (we3 == '0))
        else $error("write enable set in the cycle after reset");

    valid_clear_after_rst: assert property (@(posedge clk)
        rst |=> !res1_valid && !res2_valid)
        else $error("result valid set in the cycle after reset");

    // r0 writes must have been dropped
    no_r0_write1: assert property (@(posedge clk) disable iff (rst)
        (|we1) |-> (waddr1 != '0))
        else $error("write port 1 enabled for register 0");

    no_r0_write2: assert property (@(posedge clk) disable iff (rst)
        (|we2) |-> (waddr2 != '0))
        else $error("write port 2 enabled for register 0");

    no_r0_write3: assert property (@(posedge clk) disable iff (rst)
        (|we3) |-> (waddr3 != '0))
        else $error("write port 3 enabled for register 0");

    // result flag is the issue valid delayed by one cycle
    res1_follows_issue: assert property (@(posedge clk) disable iff (rst)
        lane1_we |=> res1_valid)
        else $error("lane 1 issue not reported one cycle later");

    res2_follows_issue: assert property (@(posedge clk) disable iff (rst)
        lane2_we |=> res2_valid)
        else $error("lane 2 issue not reported one cycle later");

endmodule

bind writeback_stage dual_issue_core_assert i_wb_checks (
    .clk        (clk),
    .rst        (rst),
    .lane1_we   (lane1_we),
    .lane2_we   (lane2_we),
    .we1        (we1),
    .waddr1     (waddr1),
    .we2        (we2),
    .waddr2     (waddr2),
    .we3        (we3),
    .waddr3     (waddr3),
    .res1_valid (res1_valid),
    .res2_valid (res2_valid)
);

`default_nettype wire

//--- tb/dual_issue_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module dual_issue_core_tb
    import cpu_types_pkg::*;
    import isa_pkg::*;
();

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 10;
    localparam int PRELOAD_CYCLES = `REG_NUM;
    localparam int RANDOM_CYCLES  = 2000;
    localparam int SLACK_CYCLES   = 20;
    // reset, preload, random traffic and some slack for idle and flush cycles
    localparam int TIMEOUT_NS     =
        (RESET_CYCLES + PRELOAD_CYCLES + RANDOM_CYCLES + SLACK_CYCLES) * CLK_PERIOD;

    logic      clk;
    logic      rst;
    logic      i1_valid;
    alu_op_t   i1_op;
    reg_addr_t i1_rs;
    reg_addr_t i1_rt;
    reg_addr_t i1_rd;
    logic      i2_valid;
    alu_op_t   i2_op;
    reg_addr_t i2_rs;
    reg_addr_t i2_rt;
    reg_addr_t i2_rd;
    logic      load_valid;
    reg_addr_t load_waddr;
    uint32_t   load_data;
    logic      res1_valid;
    uint32_t   res1_data;
    logic      res2_valid;
    uint32_t   res2_data;

    // architectural state as seen by the next bundle
    uint32_t model_regs [0:`REG_NUM-1];
    // expected results of the bundle now in writeback
    logic    exp1_valid;
    uint32_t exp1_data;
    logic    exp2_valid;
    uint32_t exp2_data;
    // 32-bit Galois LFSR, taps 32 22 2 1
    logic [31:0] lfsr_state;

    dual_issue_core i_dual_issue_core (
        .clk        (clk),
        .rst        (rst),
        .i1_valid   (i1_valid),
        .i1_op      (i1_op),
        .i1_rs      (i1_rs),
        .i1_rt      (i1_rt),
        .i1_rd      (i1_rd),
        .i2_valid   (i2_valid),
        .i2_op      (i2_op),
        .i2_rs      (i2_rs),
        .i2_rt      (i2_rt),
        .i2_rd      (i2_rd),
        .load_valid (load_valid),
        .load_waddr (load_waddr),
        .load_data  (load_data),
        .res1_valid (res1_valid),
        .res1_data  (res1_data),
        .res2_valid (res2_valid),
        .res2_data  (res2_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("simulation hung, the test did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // one LFSR step per bit, msb first
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < n; k++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // half of the picks come from r0..r7 so that ports collide often
    function automatic reg_addr_t pick_reg();
        if (take_bits(1) == 32'd1) begin
            return reg_addr_t'(take_bits(3));
        end
        return reg_addr_t'(take_bits(`REG_ADDR_W));
    endfunction

    // expected ALU behavior
    function automatic uint32_t model_alu(input alu_op_t op, input uint32_t a,
                                          input uint32_t b);
        uint32_t r;
        case (op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLL: r = a << b[4:0];
            ALU_SRL: r = a >> b[4:0];
            default: r = 32'd0;
        endcase
        return r;
    endfunction

    // r0 reads zero and ignores writes
    function automatic uint32_t model_read(input reg_addr_t r);
        return (r == '0) ? 32'd0 : model_regs[r];
    endfunction

    task automatic model_write(input reg_addr_t r, input uint32_t d);
        if (r != '0) begin
            model_regs[r] = d;
        end
    endtask

    task automatic check_value(input string what, input uint32_t actual,
                               input uint32_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // drive one bundle, then check the bundle driven one cycle before
    task automatic run_bundle(
        input logic v1, input alu_op_t op1, input reg_addr_t rs1, input reg_addr_t rt1,
        input reg_addr_t rd1,
        input logic v2, input alu_op_t op2, input reg_addr_t rs2, input reg_addr_t rt2,
        input reg_addr_t rd2,
        input logic lv, input reg_addr_t lwaddr, input uint32_t ldata
    );
        uint32_t r1;
        uint32_t r2;
        @(posedge clk);
        i1_valid   <= v1;
        i1_op      <= op1;
        i1_rs      <= rs1;
        i1_rt      <= rt1;
        i1_rd      <= rd1;
        i2_valid   <= v2;
        i2_op      <= op2;
        i2_rs      <= rs2;
        i2_rt      <= rt2;
        i2_rd      <= rd2;
        load_valid <= lv;
        load_waddr <= lwaddr;
        load_data  <= ldata;
        @(negedge clk);
        check_value("res1_valid", {31'd0, res1_valid}, {31'd0, exp1_valid});
        check_value("res2_valid", {31'd0, res2_valid}, {31'd0, exp2_valid});
        if (exp1_valid) begin
            check_value("res1_data", res1_data, exp1_data);
        end
        if (exp2_valid) begin
            check_value("res2_data", res2_data, exp2_data);
        end
        // both lanes read the state before this bundle, no intra-bundle forwarding
        r1 = model_alu(op1, model_read(rs1), model_read(rt1));
        r2 = model_alu(op2, model_read(rs2), model_read(rt2));
        exp1_valid = v1;
        exp1_data  = r1;
        exp2_valid = v2;
        exp2_data  = r2;
        // lane 1, then lane 2, then load so the load wins
        if (v1) begin
            model_write(rd1, r1);
        end
        if (v2) begin
            model_write(rd2, r2);
        end
        if (lv) begin
            model_write(lwaddr, ldata);
        end
    endtask

    task automatic idle_bundle();
        run_bundle(1'b0, ALU_ADD, '0, '0, '0, 1'b0, ALU_ADD, '0, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic random_bundle();
        logic      v1;
        logic      v2;
        logic      lv;
        alu_op_t   op1;
        alu_op_t   op2;
        reg_addr_t rs1;
        reg_addr_t rt1;
        reg_addr_t rd1;
        reg_addr_t rs2;
        reg_addr_t rt2;
        reg_addr_t rd2;
        reg_addr_t lwaddr;
        uint32_t   ldata;
        // lanes busy 3 out of 4 cycles, loads 1 out of 4
        v1     = (take_bits(2) != 32'd0);
        op1    = alu_op_t'(take_bits(3));
        rs1    = pick_reg();
        rt1    = pick_reg();
        rd1    = pick_reg();
        v2     = (take_bits(2) != 32'd0);
        op2    = alu_op_t'(take_bits(3));
        rs2    = pick_reg();
        rt2    = pick_reg();
        rd2    = pick_reg();
        lv     = (take_bits(2) == 32'd0);
        lwaddr = pick_reg();
        ldata  = take_bits(32);
        run_bundle(v1, op1, rs1, rt1, rd1, v2, op2, rs2, rt2, rd2, lv, lwaddr, ldata);
    endtask

    initial begin
        $timeformat(-9, 2, " ns", 0);
        lfsr_state = 32'd62950;
        exp1_valid = 1'b0;
        exp1_data  = '0;
        exp2_valid = 1'b0;
        exp2_data  = '0;
        rst        = 1'b1;
        i1_valid   = 1'b0;
        i1_op      = ALU_ADD;
        i1_rs      = '0;
        i1_rt      = '0;
        i1_rd      = '0;
        i2_valid   = 1'b0;
        i2_op      = ALU_ADD;
        i2_rs      = '0;
        i2_rt      = '0;
        i2_rd      = '0;
        load_valid = 1'b0;
        load_waddr = '0;
        load_data  = '0;

        // issues offered while reset is held must not show up as results
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            if (c == RESET_CYCLES - 1) begin
                rst        <= 1'b0;
                i1_valid   <= 1'b0;
                i2_valid   <= 1'b0;
                load_valid <= 1'b0;
            end else begin
                i1_valid   <= 1'b1;
                i2_valid   <= 1'b1;
                load_valid <= 1'b1;
            end
            @(negedge clk);
            check_value("res1_valid in reset", {31'd0, res1_valid}, 32'd0);
            check_value("res2_valid in reset", {31'd0, res2_valid}, 32'd0);
        end

        // quiet cycles right after reset
        idle_bundle();
        idle_bundle();

        // fill every register through the load port
        for (int r = 0; r < PRELOAD_CYCLES; r++) begin
            run_bundle(1'b0, ALU_ADD, '0, '0, '0, 1'b0, ALU_ADD, '0, '0, '0,
                       1'b1, reg_addr_t'(r), take_bits(32));
        end

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            random_bundle();
        end

        // flush the last bundle out of writeback
        idle_bundle();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
